//--- link_pkg.sv
package link_pkg;

   // ************************************************************************
   // lane geometry
   // ************************************************************************

   // one lane carries a piece this wide
   localparam int piece_width     = 4;
   // pieces that make up one core word
   localparam int pieces_per_word = 4;
   localparam int num_lanes       = 4;
   // entries in each lane buffer
   localparam int lane_depth      = 4;
   localparam int word_width      = pieces_per_word * piece_width;

   typedef logic [word_width-1:0]                word_t;
   typedef logic [piece_width-1:0]               piece_t;
   // bit n set means lane n carries pieces
   typedef logic [num_lanes-1:0]                 lane_mask_t;
   typedef logic [$clog2(num_lanes)-1:0]         lane_idx_t;
   typedef logic [$clog2(pieces_per_word)-1:0]   piece_cnt_t;
   typedef logic [$clog2(lane_depth)-1:0]        lane_ptr_t;
   // one bit wider than the pointer so a full buffer can be told from empty
   typedef logic [$clog2(lane_depth):0]          lane_fill_t;
   typedef logic [7:0]                           rx_count_t;
   typedef logic [1:0]                           wb_addr_t;

   // ************************************************************************
   // register map
   // ************************************************************************

   // write pushes a word, read pops a received word
   localparam wb_addr_t addr_data   = 2'd0;
   localparam wb_addr_t addr_mask   = 2'd1;
   // read only
   localparam wb_addr_t addr_status = 2'd2;

   localparam lane_mask_t reset_mask = '1;

   typedef enum logic {idle, deal} split_state_t;

   // lowest enabled lane, where every word starts
   function automatic lane_idx_t first_lane(lane_mask_t mask);
      lane_idx_t idx;
      idx = '0;
      // scan downward so the lowest set bit is the one kept
      for (int n = num_lanes - 1; n >= 0; n--)
      begin
         if (mask[n])
            idx = lane_idx_t'(n);
      end
      return idx;
   endfunction

   // next enabled lane after cur, wrapping around
   function automatic lane_idx_t next_lane(lane_mask_t mask, lane_idx_t cur);
      lane_idx_t idx;
      lane_idx_t cand;
      // a single enabled lane simply points back at itself
      idx = cur;
      // largest step first, so the nearest enabled lane wins
      for (int step = num_lanes - 1; step >= 1; step--)
      begin
         cand = lane_idx_t'(cur + step);
         if (mask[cand])
            idx = cand;
      end
      return idx;
   endfunction

endpackage

//--- link_lane.sv
`timescale 1ns/1ns

module link_lane import link_pkg::*;
(
   input  logic   io_master_clk,
   input  logic   arst_n_i,
   // from splitter
   input  logic   push_valid_i,
   input  piece_t push_piece_i,
   output logic   push_ready_o,
   // to assembler
   output logic   pop_valid_o,
   output piece_t pop_piece_o,
   input  logic   pop_ready_i,
   output logic   empty_o
);

   piece_t     mem_q [lane_depth];
   lane_ptr_t  wr_q;
   lane_ptr_t  rd_q;
   lane_fill_t fill_q;

   logic       do_push;
   logic       do_pop;

   assign push_ready_o = (fill_q != lane_fill_t'(lane_depth));
   assign pop_valid_o  = (fill_q != '0);
   assign empty_o      = (fill_q == '0);
   // head of the buffer, read straight from storage
   assign pop_piece_o  = mem_q[rd_q];

   assign do_push = push_valid_i & push_ready_o;
   assign do_pop  = pop_valid_o & pop_ready_i;

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge io_master_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_q   <= '0;
         rd_q   <= '0;
         fill_q <= '0;
      end
      else
      begin
         if (do_push)
            wr_q <= wr_q + 1'b1;
         if (do_pop)
            rd_q <= rd_q + 1'b1;
         // push and pop together leave the fill unchanged
         case ({do_push, do_pop})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase
      end
   end

   // storage, piece is poppable the cycle after its push
   always_ff @(posedge io_master_clk)
   begin
      if (do_push)
         mem_q[wr_q] <= push_piece_i;
   end

endmodule

//--- link_splitter.sv
`timescale 1ns/1ns

module link_splitter import link_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       arst_n_i,
   input  logic       word_valid_i,
   input  word_t      word_i,
   output logic       word_ready_o,
   input  lane_mask_t lane_mask_i,
   // one-hot push, piece shared by all lanes
   output lane_mask_t push_valid_o,
   output piece_t     push_piece_o,
   input  lane_mask_t push_ready_i,
   input  lane_mask_t lane_empty_i,
   output logic       link_idle_o
);

   split_state_t state_q;
   split_state_t state_d;
   lane_idx_t    ptr_q;
   piece_cnt_t   cnt_q;
   word_t        word_q;
   logic         ready_q;

   logic         accept;
   logic         pushed;

   // ready only comes from idle, so no state check needed here
   assign accept = word_valid_i & ready_q;
   assign pushed = (state_q == deal) & push_ready_i[ptr_q];

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         idle:
            if (accept)
               state_d = deal;
         deal:
            // last piece of the word goes out
            if (pushed && (cnt_q == piece_cnt_t'(pieces_per_word - 1)))
               state_d = idle;
         default:
            state_d = idle;
      endcase
   end

   // ************************************************************************
   // control
   // ************************************************************************

   always_ff @(posedge io_master_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= idle;
         ready_q <= 1'b0;
         ptr_q   <= first_lane(reset_mask);
         cnt_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         // registered ready, low in the cycle after a word is taken
         ready_q <= (state_d == idle);
         if (accept)
         begin
            // every word starts at the lowest enabled lane
            ptr_q <= first_lane(lane_mask_i);
            cnt_q <= '0;
         end
         else if (pushed)
         begin
            ptr_q <= next_lane(lane_mask_i, ptr_q);
            cnt_q <= piece_cnt_t'(cnt_q + 1'b1);
         end
      end
   end

   // word shifts right, lowest piece leaves first
   always_ff @(posedge io_master_clk)
   begin
      if (accept)
         word_q <= word_i;
      else if (pushed)
         word_q <= word_q >> piece_width;
   end

   assign word_ready_o = ready_q;
   assign push_valid_o = (state_q == deal) ? (lane_mask_t'(1) << ptr_q) : '0;
   assign push_piece_o = word_q[piece_width-1:0];
   assign link_idle_o  = (state_q == idle) & (&lane_empty_i);

endmodule

//--- link_assembler.sv
`timescale 1ns/1ns

module link_assembler import link_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       arst_n_i,
   input  lane_mask_t lane_mask_i,
   // from the lanes
   input  lane_mask_t pop_valid_i,
   input  piece_t     pop_piece_i [num_lanes],
   output lane_mask_t pop_ready_o,
   // rebuilt word to the slave
   output logic       rx_valid_o,
   output word_t      rx_word_o,
   input  logic       rx_pop_i
);

   logic       run_q;
   logic       held_q;
   piece_cnt_t cnt_q;
   lane_idx_t  ptr_q;
   word_t      word_q;

   lane_idx_t  cur_lane;
   logic       popped;

   // ************************************************************************
   // lane selection
   // ************************************************************************

   // at a word boundary follow the live mask, it may have changed while idle
   assign cur_lane = (cnt_q == '0) ? first_lane(lane_mask_i) : ptr_q;

   // one lane at a time, nothing while a finished word waits
   assign pop_ready_o = (run_q & ~held_q) ? (lane_mask_t'(1) << cur_lane) : '0;
   assign popped      = |(pop_ready_o & pop_valid_i);

   always_ff @(posedge io_master_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_q  <= 1'b0;
         held_q <= 1'b0;
         cnt_q  <= '0;
         ptr_q  <= first_lane(reset_mask);
      end
      else
      begin
         // keeps pop_ready low in the first cycle out of reset
         run_q <= 1'b1;
         if (rx_pop_i)
            held_q <= 1'b0;
         if (popped)
         begin
            // same rotation as the splitter
            ptr_q <= next_lane(lane_mask_i, cur_lane);
            // count wraps to zero on the last piece
            cnt_q <= piece_cnt_t'(cnt_q + 1'b1);
            if (cnt_q == piece_cnt_t'(pieces_per_word - 1))
               held_q <= 1'b1;
         end
      end
   end

   // ************************************************************************
   // word rebuild
   // ************************************************************************

   // pieces enter at the top, first piece ends up in the low bits
   always_ff @(posedge io_master_clk)
   begin
      if (popped)
         word_q <= {pop_piece_i[cur_lane], word_q[word_width-1:piece_width]};
   end

   assign rx_valid_o = held_q;
   assign rx_word_o  = word_q;

endmodule

//--- link_wb_slave.sv
`timescale 1ns/1ns

module link_wb_slave import link_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       arst_n_i,
   // wishbone classic slave
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   input  wb_addr_t   wb_adr_i,
   input  word_t      wb_dat_i,
   output logic       wb_ack_o,
   output word_t      wb_dat_o,
   // word offered to the splitter
   input  logic       word_ready_i,
   output logic       word_valid_o,
   output word_t      word_o,
   // word held by the assembler
   input  logic       rx_valid_i,
   input  word_t      rx_word_i,
   output logic       rx_pop_o,
   input  logic       link_idle_i,
   output lane_mask_t lane_mask_o
);

   logic       ack_q;
   logic       rx_pop_q;
   word_t      dat_q;
   lane_mask_t mask_q;
   rx_count_t  rx_count_q;

   logic       req;
   logic       ack_d;
   logic       pop_d;
   logic       mask_wr;
   word_t      dat_d;
   word_t      status;

   // ************************************************************************
   // address decode
   // ************************************************************************

   always_comb
   begin
      // no new request in the ack cycle, so ack stays a single pulse
      req          = wb_cyc_i & wb_stb_i & ~ack_q;
      ack_d        = 1'b0;
      pop_d        = 1'b0;
      mask_wr      = 1'b0;
      word_valid_o = 1'b0;
      dat_d        = '0;

      // status layout: count, link idle, rx valid, mask
      status                  = '0;
      status[num_lanes-1:0]   = mask_q;
      status[4]               = rx_valid_i;
      status[5]               = link_idle_i;
      status[15:8]            = rx_count_q;

      if (req)
      begin
         case (wb_adr_i)
            addr_data:
            begin
               if (wb_we_i)
               begin
                  // ack follows the splitter taking the word
                  word_valid_o = 1'b1;
                  ack_d        = word_ready_i;
               end
               else
               begin
                  // read stalls until the assembler holds a word
                  ack_d = rx_valid_i;
                  pop_d = rx_valid_i;
                  dat_d = rx_word_i;
               end
            end
            addr_mask:
            begin
               if (wb_we_i)
               begin
                  // hold off until no piece is in flight, else the two ends
                  // would disagree on the dealing order
                  ack_d   = link_idle_i;
                  // an empty mask would stop the link, drop it
                  mask_wr = link_idle_i & (wb_dat_i[num_lanes-1:0] != '0);
               end
               else
               begin
                  ack_d = 1'b1;
                  dat_d = word_t'(mask_q);
               end
            end
            addr_status:
            begin
               ack_d = 1'b1;
               dat_d = status;
            end
            // unmapped address acks with zero data
            default:
               ack_d = 1'b1;
         endcase
      end
   end

   always_ff @(posedge io_master_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ack_q      <= 1'b0;
         rx_pop_q   <= 1'b0;
         mask_q     <= reset_mask;
         rx_count_q <= '0;
      end
      else
      begin
         ack_q    <= ack_d;
         rx_pop_q <= pop_d;
         if (mask_wr)
            mask_q <= wb_dat_i[num_lanes-1:0];
         // saturating count of words handed to the core
         if (rx_pop_q && (rx_count_q != '1))
            rx_count_q <= rx_count_q + 1'b1;
      end
   end

   // read data, loaded together with the ack decision
   always_ff @(posedge io_master_clk)
   begin
      if (ack_d)
         dat_q <= dat_d;
   end

   assign wb_ack_o    = ack_q;
   assign wb_dat_o    = dat_q;
   assign word_o      = wb_dat_i;
   // pop strobe lines up with the read ack
   assign rx_pop_o    = rx_pop_q;
   assign lane_mask_o = mask_q;

endmodule

//--- link_top.sv
`timescale 1ns/1ns

module link_top import link_pkg::*;
(
   input  logic     io_master_clk,
   input  logic     arst_n_i,
   // wishbone classic slave
   input  logic     wb_cyc_i,
   input  logic     wb_stb_i,
   input  logic     wb_we_i,
   input  wb_addr_t wb_adr_i,
   input  word_t    wb_dat_i,
   output logic     wb_ack_o,
   output word_t    wb_dat_o
);

   // slave to splitter
   logic       word_valid;
   logic       word_ready;
   word_t      word;
   // assembler to slave
   logic       rx_valid;
   logic       rx_pop;
   word_t      rx_word;
   lane_mask_t lane_mask;
   logic       link_idle;

   // splitter side of the lanes
   lane_mask_t push_valid;
   lane_mask_t push_ready;
   piece_t     push_piece;
   lane_mask_t lane_empty;
   // assembler side of the lanes
   lane_mask_t pop_valid;
   lane_mask_t pop_ready;
   piece_t     pop_piece [num_lanes];

   link_wb_slave slave_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (arst_n_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_ack_o      (wb_ack_o),
      .wb_dat_o      (wb_dat_o),
      .word_ready_i  (word_ready),
      .word_valid_o  (word_valid),
      .word_o        (word),
      .rx_valid_i    (rx_valid),
      .rx_word_i     (rx_word),
      .rx_pop_o      (rx_pop),
      .link_idle_i   (link_idle),
      .lane_mask_o   (lane_mask)
   );

   link_splitter splitter_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (arst_n_i),
      .word_valid_i  (word_valid),
      .word_i        (word),
      .word_ready_o  (word_ready),
      .lane_mask_i   (lane_mask),
      .push_valid_o  (push_valid),
      .push_piece_o  (push_piece),
      .push_ready_i  (push_ready),
      .lane_empty_i  (lane_empty),
      .link_idle_o   (link_idle)
   );

   // ************************************************************************
   // lanes, the piece bus is shared and push_valid picks the target
   // ************************************************************************

   for (genvar n = 0; n < num_lanes; n++)
   begin : lane_g
      link_lane lane_i
      (
         .io_master_clk (io_master_clk),
         .arst_n_i      (arst_n_i),
         .push_valid_i  (push_valid[n]),
         .push_piece_i  (push_piece),
         .push_ready_o  (push_ready[n]),
         .pop_valid_o   (pop_valid[n]),
         .pop_piece_o   (pop_piece[n]),
         .pop_ready_i   (pop_ready[n]),
         .empty_o       (lane_empty[n])
      );
   end

   link_assembler assembler_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (arst_n_i),
      .lane_mask_i   (lane_mask),
      .pop_valid_i   (pop_valid),
      .pop_piece_i   (pop_piece),
      .pop_ready_o   (pop_ready),
      .rx_valid_o    (rx_valid),
      .rx_word_o     (rx_word),
      .rx_pop_i      (rx_pop)
   );

endmodule

//--- link_assert.sv
`timescale 1ns/1ns

module link_assert import link_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       arst_n_i,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_ack_i,
   // one bit per lane from the splitter
   input  lane_mask_t push_valid_i,
   // lanes enabled by the mask register
   input  lane_mask_t lane_mask_i,
   input  logic       rx_valid_i
);

   // read by the testbench summary
   int fail_count = 0;

   // ************************************************************************
   // wishbone handshake
   // ************************************************************************

   // ack only answers a live request
   ack_needs_req: assert property (@(posedge io_master_clk) disable iff (!arst_n_i)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
   else
   begin
      fail_count++;
      $error("wb_ack_o went high without wb_cyc_i and wb_stb_i");
   end

   // ack never lasts two cycles
   ack_single_pulse: assert property (@(posedge io_master_clk) disable iff (!arst_n_i)
      wb_ack_i |=> !wb_ack_i)
   else
   begin
      fail_count++;
      $error("wb_ack_o stayed high for more than one cycle");
   end

   // ************************************************************************
   // lanes and receive side
   // ************************************************************************

   // splitter feeds a single enabled lane per cycle
   one_lane_push: assert property (@(posedge io_master_clk) disable iff (!arst_n_i)
      $onehot0(push_valid_i) && ((push_valid_i & ~lane_mask_i) == '0))
   else
   begin
      fail_count++;
      $error("a push went to more than one lane or to a lane outside the mask");
   end

   // no word can be waiting right out of reset
   rx_empty_after_reset: assert property (@(posedge io_master_clk)
      !arst_n_i |=> !rx_valid_i)
   else
   begin
      fail_count++;
      $error("rx_valid was high in the cycle after reset");
   end

endmodule

//--- link_checker.sv
`timescale 1ns/1ns

module link_checker import link_pkg::*;
(
   input  logic     io_master_clk,
   input  logic     arst_n_i,
   // wishbone port of the DUT, watched only
   input  logic     wb_cyc_i,
   input  logic     wb_stb_i,
   input  logic     wb_we_i,
   input  wb_addr_t wb_adr_i,
   input  word_t    wb_wdata_i,
   input  logic     wb_ack_i,
   input  word_t    wb_rdata_i,
   // case currently on the bus
   input  int       case_num_i,
   input  word_t    exp_i,
   output int       done_cnt_o,
   output int       pass_cnt_o,
   output int       fail_cnt_o
);

   int done_cnt = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;

   // register name for the report lines
   function automatic string reg_name(wb_addr_t adr);
      case (adr)
         addr_data:   return "data";
         addr_mask:   return "mask";
         addr_status: return "status";
         default:     return "unmapped";
      endcase
   endfunction

   // ************************************************************************
   // compare on every completed transfer
   // ************************************************************************

   // ack is registered, so mid-cycle it and the read data are settled
   always @(negedge io_master_clk)
   begin
      if (arst_n_i && wb_cyc_i && wb_stb_i && wb_ack_i)
      begin
         done_cnt++;
         if (wb_we_i)
         begin
            // writes carry no data back, the ack is the whole result
            pass_cnt++;
            $display("case %0d: write %s <- %h acked at %0t ns",
                     case_num_i, reg_name(wb_adr_i), wb_wdata_i, $time);
         end
         else if (wb_rdata_i !== exp_i)
         begin
            fail_cnt++;
            $display("mismatch at %0t ns: wb_dat_o got %h expected %h (case %0d, %s read)",
                     $time, wb_rdata_i, exp_i, case_num_i, reg_name(wb_adr_i));
         end
         else
         begin
            pass_cnt++;
            $display("case %0d: read %s -> %h ok at %0t ns",
                     case_num_i, reg_name(wb_adr_i), wb_rdata_i, $time);
         end
      end
   end

   assign done_cnt_o = done_cnt;
   assign pass_cnt_o = pass_cnt;
   assign fail_cnt_o = fail_cnt;

endmodule

//--- tb_link_top.sv
`timescale 1ns/1ns

module tb_link_top import link_pkg::*;
();

   // case memory holds four fields per case
   localparam int max_cases = 64;
   localparam int fields    = 4;

   logic        io_master_clk;
   logic        arst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   wb_addr_t    wb_adr;
   word_t       wb_dat;
   logic        wb_ack;
   word_t       wb_rdata;

   logic [15:0] case_mem [fields*max_cases];
   int          num_cases   = 0;
   int          case_num    = 0;
   word_t       case_exp    = '0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          done_cnt;
   int          pass_cnt;
   int          fail_cnt;

   link_top dut_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (arst_n),
      .wb_cyc_i      (wb_cyc),
      .wb_stb_i      (wb_stb),
      .wb_we_i       (wb_we),
      .wb_adr_i      (wb_adr),
      .wb_dat_i      (wb_dat),
      .wb_ack_o      (wb_ack),
      .wb_dat_o      (wb_rdata)
   );

   // compares every acked read at the DUT ports
   link_checker checker_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (dut_i.arst_n_i),
      .wb_cyc_i      (dut_i.wb_cyc_i),
      .wb_stb_i      (dut_i.wb_stb_i),
      .wb_we_i       (dut_i.wb_we_i),
      .wb_adr_i      (dut_i.wb_adr_i),
      .wb_wdata_i    (dut_i.wb_dat_i),
      .wb_ack_i      (dut_i.wb_ack_o),
      .wb_rdata_i    (dut_i.wb_dat_o),
      .case_num_i    (case_num),
      .exp_i         (case_exp),
      .done_cnt_o    (done_cnt),
      .pass_cnt_o    (pass_cnt),
      .fail_cnt_o    (fail_cnt)
   );

   // protocol and lane rules inside the top level
   bind link_top link_assert assert_i
   (
      .io_master_clk (io_master_clk),
      .arst_n_i      (arst_n_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_ack_i      (wb_ack_o),
      .push_valid_i  (push_valid),
      .lane_mask_i   (lane_mask),
      .rx_valid_i    (rx_valid)
   );

   // ************************************************************************
   // clock, cycle count, watchdog
   // ************************************************************************

   initial
   begin
      io_master_clk = 1'b0;
      forever #4 io_master_clk = ~io_master_clk;
   end

   always @(posedge io_master_clk)
      cycle_count <= cycle_count + 1;

   // limit is known only once the case file is loaded
   initial
   begin : watchdog
      wait (cycle_limit != 0);
      while (cycle_count < cycle_limit)
         @(posedge io_master_clk);
      $display("timeout: no ack after %0d cycles, stuck in case %0d of %0d",
               cycle_count, case_num, num_cases);
      $display("Simulation failed");
      $finish;
   end

   // ************************************************************************
   // wishbone driver
   // ************************************************************************

   // one classic cycle with the request held until the slave acks
   task automatic wb_transfer(input logic we, input wb_addr_t adr, input word_t dat);
      @(posedge io_master_clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= we;
      wb_adr <= adr;
      wb_dat <= dat;
      // the registered ack pulse is looked for mid-cycle
      @(negedge io_master_clk);
      while (!wb_ack)
         @(negedge io_master_clk);
      @(posedge io_master_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   initial
   begin : main
      int fail_total;
      arst_n <= 1'b0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      wb_adr <= '0;
      wb_dat <= '0;
      fail_total = 0;

      // each case holds op, address, write data and expected read data
      $readmemh("link_cases.txt", case_mem);
      while ((num_cases < max_cases) && (case_mem[fields*num_cases] != 16'h000f))
         num_cases++;
      cycle_limit = 64 * num_cases + 64;

      repeat (10) @(posedge io_master_clk);
      arst_n <= 1'b1;

      for (int i = 0; i < num_cases; i++)
      begin
         case_num = i;
         case_exp = case_mem[fields*i+3];
         wb_transfer(case_mem[fields*i] == 16'h0001,
                     wb_addr_t'(case_mem[fields*i+1]),
                     case_mem[fields*i+2]);
      end

      fail_total = fail_cnt + dut_i.assert_i.fail_count;
      if (num_cases == 0)
      begin
         $display("no cases were found in link_cases.txt");
         fail_total++;
      end
      if (done_cnt != num_cases)
      begin
         $display("only %0d of %0d cases completed on the bus", done_cnt, num_cases);
         fail_total++;
      end

      $display("cases %0d, passed %0d, mismatches %0d, assertion failures %0d",
               num_cases, pass_cnt, fail_cnt, dut_i.assert_i.fail_count);
      if (fail_total == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- link_cases.txt
// op addr wdata expect, hex; op 1 write, op 0 read, op f ends the list
// addr 0 data, 1 lane mask, 2 status; expect is only compared on reads
0 2 0000 002f  // status after reset: mask f, idle, count 0
1 0 a5c3 0000  // all four lanes
1 0 1234 0000
1 0 ffe0 0000
0 0 0000 a5c3
0 0 0000 1234
0 0 0000 ffe0
1 1 000a 0000  // lanes 1 and 3 only
0 1 0000 000a
1 0 beef 0000
1 0 0f1e 0000
0 0 0000 beef
0 0 0000 0f1e
1 1 0000 0000  // empty mask is dropped
0 1 0000 000a
1 1 000f 0000  // back to all lanes
1 0 0001 0000  // five words before any read
1 0 2345 0000
1 0 6789 0000
1 0 abcd 0000
1 0 ef01 0000
0 0 0000 0001
0 0 0000 2345
0 0 0000 6789
0 0 0000 abcd
0 0 0000 ef01
0 2 0000 0a2f  // ten words received, idle, nothing held
f 0 0000 0000

//--- flist.f
link_pkg.sv
link_lane.sv
link_splitter.sv
link_assembler.sv
link_wb_slave.sv
link_top.sv
link_assert.sv
link_checker.sv
tb_link_top.sv

//--- run.sh
#!/bin/sh
# build and run the link testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_link_top \
   -f flist.f -o sim_link > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

# a failed assertion keeps the run going up to the summary line
./obj_dir/sim_link +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } \
   || grep -q "Simulation passed" sim.log \
   || { echo "FAIL, no result line in sim.log"; exit 1; }
echo "PASS"
